//--- hdl/pcs_rx_pkg.sv
package pcs_rx_pkg;

    // Block format
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;
    localparam int BLOCK_W = 66;
    localparam int WORD_W = 64;
    localparam int LANES = 8;

    // Block type field in the first payload byte of a control block
    localparam logic [7:0] BT_IDLE = 8'h1E;
    localparam logic [7:0] BT_START0 = 8'h78;
    localparam logic [7:0] BT_TERM7 = 8'hFF;

    // XGMII control characters
    localparam logic [7:0] XC_IDLE = 8'h07;
    localparam logic [7:0] XC_START = 8'hFB;
    localparam logic [7:0] XC_TERM = 8'hFD;
    localparam logic [7:0] XC_ERROR = 8'hFE;

    // Lock thresholds counted in sync headers
    localparam logic [6:0] LOCK_GOOD_CNT = 7'd64;
    localparam logic [6:0] UNLOCK_BAD_CNT = 7'd16;
    localparam logic [6:0] BER_WINDOW = 7'd64;

    // Scrambler polynomial x^58 + x^39 + 1
    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;

endpackage

//--- hdl/rx_block_if.sv
`timescale 1ns/1ps

interface rx_block_if;

    // One 66-bit block split into header and payload
    logic [pcs_rx_pkg::WORD_W-1:0] block_data;
    logic [1:0] block_header;
    logic block_valid;

    // Bit slip request back to the gearbox
    logic slip;

    modport gearbox (
        output block_data,
        output block_header,
        output block_valid,
        input slip
    );

    modport lock (
        input block_header,
        input block_valid,
        output slip
    );

    modport sink (
        input block_data,
        input block_header,
        input block_valid
    );

endinterface

//--- hdl/rx_gearbox.sv
`timescale 1ns/1ps

module rx_gearbox (
    input logic i_rxc,
    input logic i_rst_n,
    input logic [pcs_rx_pkg::WORD_W-1:0] i_rxd,
    rx_block_if.gearbox o_blk
);

    // Holds up to 65 leftover bits plus one new word
    logic [pcs_rx_pkg::WORD_W+pcs_rx_pkg::BLOCK_W-1:0] buf_q;
    logic [7:0] fill_q;

    logic [pcs_rx_pkg::WORD_W+pcs_rx_pkg::BLOCK_W-1:0] merged;
    logic [7:0] merged_fill;
    logic emit;

    always_comb begin
        // New word lands right above the bits already held
        merged = buf_q | ({{pcs_rx_pkg::BLOCK_W{1'b0}}, i_rxd} << fill_q);
        merged_fill = fill_q + 8'(pcs_rx_pkg::WORD_W);
        // Slip drops the oldest buffered bit
        if (o_blk.slip) begin
            merged = merged >> 1;
            merged_fill = merged_fill - 8'd1;
        end
        emit = (merged_fill >= 8'(pcs_rx_pkg::BLOCK_W));
    end

    // Bits above the fill level must stay zero for the merge above
    always_ff @(posedge i_rxc) begin
        if (!i_rst_n) begin
            buf_q <= '0;
            fill_q <= 8'd0;
            o_blk.block_valid <= 1'b0;
        end else if (emit) begin
            buf_q <= merged >> pcs_rx_pkg::BLOCK_W;
            fill_q <= merged_fill - 8'(pcs_rx_pkg::BLOCK_W);
            o_blk.block_valid <= 1'b1;
        end else begin
            buf_q <= merged;
            fill_q <= merged_fill;
            o_blk.block_valid <= 1'b0;
        end
    end

    // Oldest bits form the block with the header first on the wire
    always_ff @(posedge i_rxc) begin
        if (emit) begin
            o_blk.block_header <= merged[1:0];
            o_blk.block_data <= merged[pcs_rx_pkg::BLOCK_W-1:2];
        end
    end

    // At most one gap per 33 cycles, so gaps never pair up without a slip
    a_no_double_gap: assert property (
        @(posedge i_rxc) disable iff (!i_rst_n)
        ($past(i_rst_n, 2) && !$past(o_blk.block_valid) && !o_blk.block_valid)
            |-> $past(o_blk.slip)
    );

endmodule

//--- hdl/block_lock.sv
`timescale 1ns/1ps

module block_lock (
    input logic i_rxc,
    input logic i_rst_n,
    rx_block_if.lock i_blk,
    output logic o_block_lock
);

    logic [6:0] good_cnt;
    logic [6:0] hdr_cnt;
    logic [6:0] bad_cnt;
    logic skip_next;
    logic hdr_good;

    assign hdr_good = (i_blk.block_header == pcs_rx_pkg::SYNC_DATA)
        || (i_blk.block_header == pcs_rx_pkg::SYNC_CTRL);

    always_ff @(posedge i_rxc) begin
        if (!i_rst_n) begin
            good_cnt <= 7'd0;
            hdr_cnt <= 7'd0;
            bad_cnt <= 7'd0;
            skip_next <= 1'b0;
            i_blk.slip <= 1'b0;
            o_block_lock <= 1'b0;
        end else begin
            i_blk.slip <= 1'b0;
            if (i_blk.block_valid) begin
                if (skip_next) begin
                    // Block was cut before the slip took effect
                    skip_next <= 1'b0;
                end else if (!o_block_lock) begin
                    if (!hdr_good) begin
                        good_cnt <= 7'd0;
                        i_blk.slip <= 1'b1;
                        skip_next <= 1'b1;
                    end else if (good_cnt == pcs_rx_pkg::LOCK_GOOD_CNT - 7'd1) begin
                        good_cnt <= 7'd0;
                        hdr_cnt <= 7'd0;
                        bad_cnt <= 7'd0;
                        o_block_lock <= 1'b1;
                    end else begin
                        good_cnt <= good_cnt + 7'd1;
                    end
                end else if (!hdr_good && bad_cnt == pcs_rx_pkg::UNLOCK_BAD_CNT - 7'd1) begin
                    // Too many errors in this window
                    o_block_lock <= 1'b0;
                    hdr_cnt <= 7'd0;
                    bad_cnt <= 7'd0;
                end else if (hdr_cnt == pcs_rx_pkg::BER_WINDOW - 7'd1) begin
                    hdr_cnt <= 7'd0;
                    bad_cnt <= 7'd0;
                end else begin
                    hdr_cnt <= hdr_cnt + 7'd1;
                    bad_cnt <= bad_cnt + {6'd0, !hdr_good};
                end
            end
        end
    end

    // Gearbox alignment must hold still once locked
    a_no_slip_locked: assert property (
        @(posedge i_rxc) disable iff (!i_rst_n)
        !(i_blk.slip && o_block_lock)
    );

endmodule

//--- hdl/descrambler.sv
`timescale 1ns/1ps

module descrambler (
    input logic i_rxc,
    input logic i_rst_n,
    rx_block_if.sink i_blk,
    output logic [pcs_rx_pkg::WORD_W-1:0] o_plain
);

    // hist[0] is the oldest bit, hist[57] the one just before data bit 0
    logic [pcs_rx_pkg::SCR_TAP_B-1:0] hist;
    logic [pcs_rx_pkg::WORD_W+pcs_rx_pkg::SCR_TAP_B-1:0] stream;

    assign stream = {i_blk.block_data, hist};

    always_comb begin
        for (int i = 0; i < pcs_rx_pkg::WORD_W; i++) begin
            o_plain[i] = stream[i + pcs_rx_pkg::SCR_TAP_B]
                ^ stream[i + pcs_rx_pkg::SCR_TAP_B - pcs_rx_pkg::SCR_TAP_A]
                ^ stream[i];
        end
    end

    // Keep the last 58 scrambled bits seen on the line
    always_ff @(posedge i_rxc) begin
        if (!i_rst_n) begin
            hist <= '0;
        end else if (i_blk.block_valid) begin
            hist <= i_blk.block_data[pcs_rx_pkg::WORD_W-1:
                pcs_rx_pkg::WORD_W-pcs_rx_pkg::SCR_TAP_B];
        end
    end

endmodule

//--- hdl/decode_6466b.sv
`timescale 1ns/1ps

module decode_6466b (
    input logic i_rxc,
    input logic i_rst_n,
    rx_block_if.sink i_blk,
    input logic [pcs_rx_pkg::WORD_W-1:0] i_plain,
    output logic [pcs_rx_pkg::WORD_W-1:0] o_rxd,
    output logic [pcs_rx_pkg::LANES-1:0] o_rxctl,
    output logic o_rx_valid
);

    logic [pcs_rx_pkg::WORD_W-1:0] dec_rxd;
    logic [pcs_rx_pkg::LANES-1:0] dec_rxctl;
    logic [7:0] block_type;

    // Type field sits in the first payload byte
    assign block_type = i_plain[7:0];

    always_comb begin
        dec_rxd = {pcs_rx_pkg::LANES{pcs_rx_pkg::XC_ERROR}};
        dec_rxctl = '1;
        if (i_blk.block_header == pcs_rx_pkg::SYNC_DATA) begin
            dec_rxd = i_plain;
            dec_rxctl = '0;
        end else if (i_blk.block_header == pcs_rx_pkg::SYNC_CTRL) begin
            case (block_type)
                pcs_rx_pkg::BT_IDLE: begin
                    dec_rxd = {pcs_rx_pkg::LANES{pcs_rx_pkg::XC_IDLE}};
                    dec_rxctl = '1;
                end
                pcs_rx_pkg::BT_START0: begin
                    dec_rxd = {i_plain[63:8], pcs_rx_pkg::XC_START};
                    dec_rxctl = 8'h01;
                end
                // Seven data bytes then terminate in the last lane
                pcs_rx_pkg::BT_TERM7: begin
                    dec_rxd = {pcs_rx_pkg::XC_TERM, i_plain[63:8]};
                    dec_rxctl = 8'h80;
                end
                default: begin
                    dec_rxd = {pcs_rx_pkg::LANES{pcs_rx_pkg::XC_ERROR}};
                    dec_rxctl = '1;
                end
            endcase
        end
    end

    always_ff @(posedge i_rxc) begin
        if (!i_rst_n) begin
            o_rxd <= {pcs_rx_pkg::LANES{pcs_rx_pkg::XC_IDLE}};
            o_rxctl <= '1;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= i_blk.block_valid;
            // Hold the last word through gearbox gaps
            if (i_blk.block_valid) begin
                o_rxd <= dec_rxd;
                o_rxctl <= dec_rxctl;
            end
        end
    end

    // Only the four supported lane patterns can leave the decoder
    a_ctl_pattern: assert property (
        @(posedge i_rxc) disable iff (!i_rst_n)
        o_rx_valid |-> (o_rxctl inside {8'h00, 8'h01, 8'h80, 8'hFF})
    );

endmodule

//--- hdl/pcs_rx.sv
`timescale 1ns/1ps

module pcs_rx (
    input logic i_rxc,
    input logic i_rst_n,
    input logic [pcs_rx_pkg::WORD_W-1:0] i_rxd,
    output logic [pcs_rx_pkg::WORD_W-1:0] o_rxd,
    output logic [pcs_rx_pkg::LANES-1:0] o_rxctl,
    output logic o_rx_valid,
    output logic o_block_lock
);

    rx_block_if blk ();

    // Descrambled payload on its way to the decoder
    logic [pcs_rx_pkg::WORD_W-1:0] plain;

    rx_gearbox u_gearbox (
        .i_rxc(i_rxc),
        .i_rst_n(i_rst_n),
        .i_rxd(i_rxd),
        .o_blk(blk.gearbox)
    );

    block_lock u_lock (
        .i_rxc(i_rxc),
        .i_rst_n(i_rst_n),
        .i_blk(blk.lock),
        .o_block_lock(o_block_lock)
    );

    descrambler u_descrambler (
        .i_rxc(i_rxc),
        .i_rst_n(i_rst_n),
        .i_blk(blk.sink),
        .o_plain(plain)
    );

    decode_6466b u_decoder (
        .i_rxc(i_rxc),
        .i_rst_n(i_rst_n),
        .i_blk(blk.sink),
        .i_plain(plain),
        .o_rxd(o_rxd),
        .o_rxctl(o_rxctl),
        .o_rx_valid(o_rx_valid)
    );

endmodule

//--- verification/pcs_rx_tb.sv
`timescale 1ns/1ps

module pcs_rx_tb;

    localparam int SEED = 89588;
    localparam int LOCK_TIMEOUT = 4000;
    localparam int RUN_TIMEOUT = 1500;
    localparam int RUN_WORDS = 300;
    localparam int MATCH_LEN = 9;
    localparam int BURST_LEN = 20;
    localparam int GAP_CYCLES = 33;

    logic i_rxc;
    logic i_rst_n;
    logic [pcs_rx_pkg::WORD_W-1:0] i_rxd;
    logic [pcs_rx_pkg::WORD_W-1:0] o_rxd;
    logic [pcs_rx_pkg::LANES-1:0] o_rxctl;
    logic o_rx_valid;
    logic o_block_lock;

    // Line bits oldest first and decoded words as {ctl, data}
    bit line_bits[$];
    logic [71:0] expected[$];
    logic [71:0] observed[$];
    // scr_state[0] holds the bit sent 58 bits back
    logic [pcs_rx_pkg::SCR_TAP_B-1:0] scr_state;
    int idle_left = 2;
    int data_left = -1;
    int burst_left = 0;
    bit inject_error = 1'b0;
    int errors = 0;
    int checked = 0;
    int skip_left = 2;
    int win_cnt = 0;
    int lock_drops = 0;
    int drops_before = 0;
    int target = 0;
    bit was_locked = 1'b0;
    bit aligned = 1'b0;
    bit abort = 1'b0;
    longint cycle = 0;
    longint last_gap = -1;

    pcs_rx i_dut (
        .i_rxc(i_rxc),
        .i_rst_n(i_rst_n),
        .i_rxd(i_rxd),
        .o_rxd(o_rxd),
        .o_rxctl(o_rxctl),
        .o_rx_valid(o_rx_valid),
        .o_block_lock(o_block_lock)
    );

    initial begin
        i_rxc = 1'b0;
        forever #5 i_rxc = ~i_rxc;
    end

    // Transmit model scrambling the payload bit by bit onto the line
    task automatic send_block(input logic [1:0] hdr, input logic [63:0] plain,
        input logic [71:0] want);
        logic s;
        line_bits.push_back(hdr[0]);
        line_bits.push_back(hdr[1]);
        for (int i = 0; i < pcs_rx_pkg::WORD_W; i++) begin
            s = plain[i] ^ scr_state[pcs_rx_pkg::SCR_TAP_B - pcs_rx_pkg::SCR_TAP_A]
                ^ scr_state[0];
            scr_state = {s, scr_state[pcs_rx_pkg::SCR_TAP_B-1:1]};
            line_bits.push_back(s);
        end
        expected.push_back(want);
    endtask

    task automatic push_junk();
        int n;
        n = $urandom_range(0, pcs_rx_pkg::BLOCK_W - 1);
        for (int i = 0; i < n; i++) begin
            line_bits.push_back(1'($urandom_range(0, 1)));
        end
    endtask

    // Idle runs and packets of start, data and terminate blocks
    task automatic next_block();
        logic [63:0] d;
        d = {$urandom, $urandom};
        if (burst_left > 0 || inject_error) begin
            // Header 00 or 11
            send_block({2{d[0]}}, d, {8'hFF, {pcs_rx_pkg::LANES{pcs_rx_pkg::XC_ERROR}}});
            inject_error = 1'b0;
            if (burst_left == 1) begin
                push_junk();
            end
            if (burst_left > 0) begin
                burst_left--;
            end
        end else if (idle_left > 0) begin
            idle_left--;
            send_block(pcs_rx_pkg::SYNC_CTRL, {56'd0, pcs_rx_pkg::BT_IDLE},
                {8'hFF, {pcs_rx_pkg::LANES{pcs_rx_pkg::XC_IDLE}}});
        end else if (data_left < 0) begin
            data_left = $urandom_range(1, 6);
            send_block(pcs_rx_pkg::SYNC_CTRL, {d[63:8], pcs_rx_pkg::BT_START0},
                {8'h01, d[63:8], pcs_rx_pkg::XC_START});
        end else if (data_left > 0) begin
            data_left--;
            send_block(pcs_rx_pkg::SYNC_DATA, d, {8'h00, d});
        end else begin
            data_left = -1;
            idle_left = $urandom_range(1, 4);
            send_block(pcs_rx_pkg::SYNC_CTRL, {d[63:8], pcs_rx_pkg::BT_TERM7},
                {8'h80, pcs_rx_pkg::XC_TERM, d[63:8]});
        end
    endtask

    task automatic drive_line();
        logic [pcs_rx_pkg::WORD_W-1:0] word;
        forever begin
            @(posedge i_rxc);
            while (line_bits.size() < pcs_rx_pkg::WORD_W) begin
                next_block();
            end
            for (int i = 0; i < pcs_rx_pkg::WORD_W; i++) begin
                word[i] = line_bits.pop_front();
            end
            i_rxd <= word;
        end
    endtask

    task automatic compare_word();
        logic [71:0] want;
        assert (expected.size() > 0) else begin
            errors++;
            $display("Decoded word at %0t arrived with no expected word left", $time);
        end
        if (expected.size() > 0) begin
            want = expected.pop_front();
            checked++;
            assert (o_rxd === want[63:0]) else begin
                errors++;
                $display("Fail at %0t: o_rxd got %h expected %h", $time, o_rxd, want[63:0]);
            end
            assert (o_rxctl === want[71:64]) else begin
                errors++;
                $display("Fail at %0t: o_rxctl got %h expected %h", $time, o_rxctl,
                    want[71:64]);
            end
        end
    endtask

    task automatic find_alignment();
        int pos;
        bit hit;
        pos = 0;
        hit = 1'b0;
        while (!hit && pos + MATCH_LEN <= expected.size()) begin
            hit = 1'b1;
            for (int k = 0; k < MATCH_LEN; k++) begin
                if (expected[pos + k] !== observed[k]) begin
                    hit = 1'b0;
                end
            end
            pos++;
        end
        assert (hit) else begin
            errors++;
            $display("No run of expected words matches the words decoded up to %0t", $time);
        end
        // Words ahead of the match went out while the receiver was not locked
        if (hit) begin
            repeat (pos + MATCH_LEN - 1) begin
                void'(expected.pop_front());
            end
            checked += MATCH_LEN;
            aligned = 1'b1;
        end
        observed.delete();
    endtask

    always @(negedge i_rxc) begin
        cycle++;
        if (o_block_lock !== 1'b1) begin
            if (was_locked) begin
                lock_drops++;
            end
            was_locked = 1'b0;
            aligned = 1'b0;
            skip_left = 2;
            win_cnt = 0;
            last_gap = -1;
            observed.delete();
        end else if (!o_rx_valid) begin
            was_locked = 1'b1;
            // 32 blocks of 66 bits in 33 words of 64 bits
            assert (last_gap < 0 || cycle - last_gap == GAP_CYCLES) else begin
                errors++;
                $display("Fail at %0t: o_rx_valid gap spacing got %0d expected %0d",
                    $time, cycle - last_gap, GAP_CYCLES);
            end
            last_gap = cycle;
        end else begin
            was_locked = 1'b1;
            win_cnt++;
            if (skip_left > 0) begin
                skip_left--;
            end else if (aligned) begin
                compare_word();
            end else begin
                observed.push_back({o_rxctl, o_rxd});
                if (observed.size() == MATCH_LEN) begin
                    find_alignment();
                end
            end
        end
    end

    // Step 0 lock up, 1 lock down, 2 word count, 3 early in a header window
    function automatic bit reached(input int step, input int goal);
        case (step)
            0: reached = (o_block_lock === 1'b1);
            1: reached = (o_block_lock === 1'b0);
            2: reached = (checked >= goal);
            default: reached = (win_cnt % int'(pcs_rx_pkg::BER_WINDOW) == 3);
        endcase
    endfunction

    task automatic wait_until(input int step, input int goal, input int limit,
        input string what);
        int n;
        n = 0;
        do begin
            @(posedge i_rxc);
            n++;
        end while (!reached(step, goal) && n < limit);
        assert (reached(step, goal)) else begin
            errors++;
            abort = 1'b1;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst_n = 1'b0;
        i_rxd = '0;
        scr_state = pcs_rx_pkg::SCR_TAP_B'({$urandom, $urandom});
        // Leading junk bits set the block offset on the line
        push_junk();
        repeat (3) @(posedge i_rxc);
        i_rst_n <= 1'b1;
        fork
            drive_line();
        join_none
        wait_until(0, 0, LOCK_TIMEOUT, "block lock");
        if (!abort) begin
            wait_until(2, checked + RUN_WORDS, RUN_TIMEOUT, "decoded words after lock");
        end
        if (!abort) begin
            drops_before = lock_drops;
            target = checked + RUN_WORDS;
            @(negedge i_rxc);
            inject_error = 1'b1;
            wait_until(2, target, RUN_TIMEOUT, "decoded words after one bad header");
        end
        if (!abort) begin
            assert (lock_drops == drops_before) else begin
                errors++;
                $display("Block lock was lost after a single bad sync header");
            end
            // Burst early in a window so every bad header counts
            wait_until(3, 0, RUN_TIMEOUT, "the start of a header window");
        end
        if (!abort) begin
            @(negedge i_rxc);
            burst_left = BURST_LEN;
            wait_until(1, 0, RUN_TIMEOUT, "loss of lock after the bad header burst");
        end
        if (!abort) begin
            wait_until(0, 0, LOCK_TIMEOUT, "block lock after the burst");
        end
        if (!abort) begin
            wait_until(2, checked + RUN_WORDS, RUN_TIMEOUT, "decoded words after relock");
        end
        $display("Checked %0d decoded words, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/pcs_rx_pkg.sv
hdl/rx_block_if.sv
hdl/rx_gearbox.sv
hdl/block_lock.sv
hdl/descrambler.sv
hdl/decode_6466b.sv
hdl/pcs_rx.sv
verification/pcs_rx_tb.sv
